/* debug_display_pkg.sv */
//==========================================================
// Shared widths, page numbering and seven-segment font for
// the debug display datapath
//==========================================================
`default_nettype none

package debug_display_pkg;

    localparam int PAGE_WIDTH  = 128;
    // Three pages per query or subject block
    localparam int BLOCK_WIDTH = 384;

    // Pages 0 to 12 are mapped, the rest read as zero
    typedef logic [3:0] page_sel_t;

    typedef struct packed {
        logic [BLOCK_WIDTH-1:0] query_data;
        logic [BLOCK_WIDTH-1:0] subject_data;
        logic [87:0]            misc_debug;
        logic [BLOCK_WIDTH-1:0] query_debug;
        logic [BLOCK_WIDTH-1:0] subject_debug;
    } debug_src_t;

    // Segment order gfedcba, active low
    typedef logic [6:0] seg_t;

    localparam seg_t SEG_FONT [0:15] = '{
        7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
        7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,
        7'b0000000, 7'b0011000, 7'b0001000, 7'b0000011,
        7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110
    };

endpackage

`default_nettype wire

/* lcd_pkg.sv */
//==========================================================
// Character LCD bus, screen text and HD44780 commands
//==========================================================
`default_nettype none

package lcd_pkg;

    // Pins of the 2x16 character module
    typedef struct packed {
        logic [7:0] data;
        logic       rs;
        logic       rw;
        logic       en;
        logic       on;
    } lcd_bus_t;

    // Index 0 is the top-left character, 16 starts line 2
    typedef logic [31:0][7:0] lcd_text_t;

    //==========================================================
    // HD44780 instruction bytes
    //==========================================================
    // 8-bit bus, two lines, 5x8 dots
    localparam logic [7:0] CMD_FUNCTION_SET = 8'h38;
    // Display on, cursor and blink off
    localparam logic [7:0] CMD_DISPLAY_ON   = 8'h0C;
    localparam logic [7:0] CMD_CLEAR        = 8'h01;
    // Increment address, no shift
    localparam logic [7:0] CMD_ENTRY_MODE   = 8'h06;
    // DDRAM address of each line start
    localparam logic [7:0] CMD_LINE1        = 8'h80;
    localparam logic [7:0] CMD_LINE2        = 8'hC0;

endpackage

`default_nettype wire

/* reset_delay.sv */
//==========================================================
// Stretches the LCD reset past system reset or a write_lcd
// pulse so the controller restarts its init sequence
//==========================================================
`timescale 1ns/1ps
`default_nettype none

module reset_delay #(
    parameter int RESET_DELAY_CYCLES = 1000
) (
    input  wire logic clock_50,
    input  wire logic reset,
    input  wire logic write_lcd,
    output logic      lcd_reset
);

    localparam int CNT_W = $clog2(RESET_DELAY_CYCLES + 1);

    logic [CNT_W-1:0] count;

    // Reload on either event, then count up and hold at the limit
    always_ff @(posedge clock_50) begin
        if (reset || write_lcd) begin
            count <= '0;
        end else if (count != CNT_W'(RESET_DELAY_CYCLES)) begin
            count <= count + 1'b1;
        end
    end

    assign lcd_reset = (count != CNT_W'(RESET_DELAY_CYCLES));

endmodule

`default_nettype wire

/* page_select.sv */
//==========================================================
// Registered page mux that picks one 128-bit debug page
// for the LCD from the switch field
//==========================================================
`timescale 1ns/1ps
`default_nettype none

module page_select (
    input  wire logic                                   clock_50,
    input  wire logic                                   reset,
    input  wire debug_display_pkg::page_sel_t           sel,
    input  wire debug_display_pkg::debug_src_t          debug,
    output logic [debug_display_pkg::PAGE_WIDTH-1:0]    page
);

    localparam int PW = debug_display_pkg::PAGE_WIDTH;

    logic [PW-1:0] page_next;

    // Three pages per block, lowest bits first
    always_comb begin
        case (sel)
            4'd0:    page_next = debug.query_data[0*PW +: PW];
            4'd1:    page_next = debug.query_data[1*PW +: PW];
            4'd2:    page_next = debug.query_data[2*PW +: PW];
            4'd3:    page_next = debug.subject_data[0*PW +: PW];
            4'd4:    page_next = debug.subject_data[1*PW +: PW];
            4'd5:    page_next = debug.subject_data[2*PW +: PW];
            // Misc word is narrower than a page
            4'd6:    page_next = PW'(debug.misc_debug);
            4'd7:    page_next = debug.query_debug[0*PW +: PW];
            4'd8:    page_next = debug.query_debug[1*PW +: PW];
            4'd9:    page_next = debug.query_debug[2*PW +: PW];
            4'd10:   page_next = debug.subject_debug[0*PW +: PW];
            4'd11:   page_next = debug.subject_debug[1*PW +: PW];
            4'd12:   page_next = debug.subject_debug[2*PW +: PW];
            default: page_next = '0;
        endcase
    end

    always_ff @(posedge clock_50) begin
        if (reset) begin
            page <= '0;
        end else begin
            page <= page_next;
        end
    end

endmodule

`default_nettype wire

/* hex_ascii_encoder.sv */
//==========================================================
// Converts a debug page into 32 ASCII hex characters with
// the most significant nibble at the top left
//==========================================================
`timescale 1ns/1ps
`default_nettype none

module hex_ascii_encoder (
    input  wire logic [debug_display_pkg::PAGE_WIDTH-1:0] page,
    output lcd_pkg::lcd_text_t                           text
);

    localparam int NIBBLES = debug_display_pkg::PAGE_WIDTH / 4;

    // 0-9 map to '0'-'9', A-F to 'A'-'F'
    function automatic logic [7:0] nibble_to_ascii(input logic [3:0] nib);
        if (nib < 4'd10) begin
            return {4'h3, nib};
        end
        return 8'h37 + {4'h0, nib};
    endfunction

    // Character k takes nibble NIBBLES-1-k
    always_comb begin
        for (int k = 0; k < NIBBLES; k++) begin
            text[k] = nibble_to_ascii(page[4*(NIBBLES-1-k) +: 4]);
        end
    end

endmodule

`default_nettype wire

/* seven_seg_bank.sv */
//==========================================================
// Eight-digit hex display of the subject ID or length,
// chosen by one switch
//==========================================================
`timescale 1ns/1ps
`default_nettype none

module seven_seg_bank (
    input  wire logic                          clock_50,
    input  wire logic                          reset,
    input  wire logic                          show_id,
    input  wire logic [31:0]                   subject_id,
    input  wire logic [31:0]                   subject_length,
    output debug_display_pkg::seg_t [7:0]      hex
);

    logic [31:0] word;

    assign word = show_id ? subject_id : subject_length;

    //==========================================================
    // Font lookup, one digit per nibble
    //==========================================================
    always_ff @(posedge clock_50) begin
        if (reset) begin
            // All segments off
            hex <= '1;
        end else begin
            for (int k = 0; k < 8; k++) begin
                hex[k] <= debug_display_pkg::SEG_FONT[word[4*k +: 4]];
            end
        end
    end

endmodule

`default_nettype wire

/* status_leds.sv */
//==========================================================
// Status word on the red and green LEDs plus a heartbeat
// blink on the last green LED
//==========================================================
`timescale 1ns/1ps
`default_nettype none

module status_leds #(
    parameter int HEARTBEAT_HALF = 25_000_000
) (
    input  wire logic        clock_50,
    input  wire logic        reset,
    input  wire logic [25:0] status,
    output logic      [17:0] ledr,
    output logic      [8:0]  ledg
);

    localparam int CNT_W = $clog2(HEARTBEAT_HALF + 1);

    logic [CNT_W-1:0] beat_count;
    logic             beat;
    logic [7:0]       status_low;

    // Upper 18 bits red, lower 8 bits green
    always_ff @(posedge clock_50) begin
        ledr       <= status[25:8];
        status_low <= status[7:0];
    end

    // Toggle once per half period
    always_ff @(posedge clock_50) begin
        if (reset) begin
            beat_count <= '0;
            beat       <= 1'b0;
        end else if (beat_count == CNT_W'(HEARTBEAT_HALF - 1)) begin
            beat_count <= '0;
            beat       <= ~beat;
        end else begin
            beat_count <= beat_count + 1'b1;
        end
    end

    assign ledg = {beat, status_low};

endmodule

`default_nettype wire

/* lcd_controller.sv */
//==========================================================
// HD44780 controller: sends the init commands once, then
// rewrites both text lines in an endless loop
//==========================================================
`timescale 1ns/1ps
`default_nettype none

module lcd_controller #(
    parameter int EN_CYCLES  = 12,
    parameter int GAP_CYCLES = 2000
) (
    input  wire logic               clock_50,
    input  wire logic               lcd_reset,
    input  wire lcd_pkg::lcd_text_t text,
    output lcd_pkg::lcd_bus_t       lcd
);

    localparam int TOTAL   = EN_CYCLES + GAP_CYCLES;
    localparam int TIMER_W = $clog2(TOTAL);

    typedef enum logic [1:0] {
        PH_INIT,
        PH_LINE1,
        PH_LINE2,
        PH_HOME
    } phase_t;

    phase_t             phase;
    logic [4:0]         idx;
    logic [TIMER_W-1:0] timer;
    logic [7:0]         next_byte;
    logic               next_rs;
    logic [7:0]         data_q;
    logic               rs_q;
    logic               en_q;

    //==========================================================
    // Byte for the transfer about to start
    //==========================================================
    always_comb begin
        next_byte = lcd_pkg::CMD_LINE1;
        next_rs   = 1'b0;
        case (phase)
            PH_INIT: begin
                case (idx[1:0])
                    2'd0:    next_byte = lcd_pkg::CMD_FUNCTION_SET;
                    2'd1:    next_byte = lcd_pkg::CMD_DISPLAY_ON;
                    2'd2:    next_byte = lcd_pkg::CMD_CLEAR;
                    default: next_byte = lcd_pkg::CMD_ENTRY_MODE;
                endcase
            end
            PH_LINE1: begin
                // Last slot of line 1 moves the cursor down
                if (idx == 5'd16) begin
                    next_byte = lcd_pkg::CMD_LINE2;
                end else begin
                    next_byte = text[{1'b0, idx[3:0]}];
                    next_rs   = 1'b1;
                end
            end
            PH_LINE2: begin
                next_byte = text[{1'b1, idx[3:0]}];
                next_rs   = 1'b1;
            end
            default: next_byte = lcd_pkg::CMD_LINE1;
        endcase
    end

    //==========================================================
    // Transfer timing and sequencing
    //==========================================================
    always_ff @(posedge clock_50) begin
        if (lcd_reset) begin
            phase  <= PH_INIT;
            idx    <= '0;
            timer  <= '0;
            data_q <= '0;
            rs_q   <= 1'b0;
            en_q   <= 1'b0;
        end else begin
            // Text is sampled here, at the start of the transfer
            if (timer == '0) begin
                data_q <= next_byte;
                rs_q   <= next_rs;
                en_q   <= 1'b1;
            end
            // Falling edge latches the byte in the LCD
            if (timer == TIMER_W'(EN_CYCLES)) begin
                en_q <= 1'b0;
            end
            if (timer == TIMER_W'(TOTAL - 1)) begin
                timer <= '0;
                idx   <= idx + 1'b1;
                case (phase)
                    PH_INIT: if (idx == 5'd3) begin
                        phase <= PH_LINE1;
                        idx   <= '0;
                    end
                    PH_LINE1: if (idx == 5'd16) begin
                        phase <= PH_LINE2;
                        idx   <= '0;
                    end
                    PH_LINE2: if (idx == 5'd15) begin
                        phase <= PH_HOME;
                        idx   <= '0;
                    end
                    default: begin
                        phase <= PH_LINE1;
                        idx   <= '0;
                    end
                endcase
            end else begin
                timer <= timer + 1'b1;
            end
        end
    end

    // Write-only bus, backlight always on
    assign lcd = {data_q, rs_q, 1'b0, en_q, 1'b1};

endmodule

`default_nettype wire

/* debug_display_top.sv */
//==========================================================
// Board top for the debug display: LCD page viewer, hex
// digits and status LEDs
//==========================================================
`timescale 1ns/1ps
`default_nettype none

module debug_display_top #(
    parameter int RESET_DELAY_CYCLES = 1000,
    parameter int EN_CYCLES          = 12,
    parameter int GAP_CYCLES         = 2000,
    parameter int HEARTBEAT_HALF     = 25_000_000
) (
    input  wire logic                          clock_50,
    input  wire logic                          reset,
    input  wire logic [17:0]                   sw,
    input  wire debug_display_pkg::debug_src_t debug,
    input  wire logic [31:0]                   subject_id,
    input  wire logic [31:0]                   subject_length,
    input  wire logic [25:0]                   status,
    input  wire logic                          write_lcd,
    output debug_display_pkg::seg_t [7:0]      hex,
    output logic [17:0]                        ledr,
    output logic [8:0]                         ledg,
    output lcd_pkg::lcd_bus_t                  lcd
);

    logic [debug_display_pkg::PAGE_WIDTH-1:0] page;
    lcd_pkg::lcd_text_t                       text;
    logic                                     lcd_reset;

    //==========================================================
    // LCD path
    //==========================================================
    reset_delay #(.RESET_DELAY_CYCLES(RESET_DELAY_CYCLES)) reset_delay_i (
        .clock_50  (clock_50),
        .reset     (reset),
        .write_lcd (write_lcd),
        .lcd_reset (lcd_reset)
    );

    // Switches 17:14 pick the page
    page_select page_select_i (
        .clock_50 (clock_50),
        .reset    (reset),
        .sel      (sw[17:14]),
        .debug    (debug),
        .page     (page)
    );

    hex_ascii_encoder hex_ascii_encoder_i (
        .page (page),
        .text (text)
    );

    lcd_controller #(
        .EN_CYCLES  (EN_CYCLES),
        .GAP_CYCLES (GAP_CYCLES)
    ) lcd_controller_i (
        .clock_50  (clock_50),
        .lcd_reset (lcd_reset),
        .text      (text),
        .lcd       (lcd)
    );

    //==========================================================
    // Digits and LEDs
    //==========================================================
    seven_seg_bank seven_seg_bank_i (
        .clock_50       (clock_50),
        .reset          (reset),
        .show_id        (sw[10]),
        .subject_id     (subject_id),
        .subject_length (subject_length),
        .hex            (hex)
    );

    status_leds #(.HEARTBEAT_HALF(HEARTBEAT_HALF)) status_leds_i (
        .clock_50 (clock_50),
        .reset    (reset),
        .status   (status),
        .ledr     (ledr),
        .ledg     (ledg)
    );

endmodule

`default_nettype wire

/* debug_display_assert.sv */
//==========================================================
// LCD bus protocol checks, bound into the LCD controller
//==========================================================
`timescale 1ns/1ps
`default_nettype none

module debug_display_assert #(
    parameter int EN_CYCLES = 12
) (
    input wire logic              clock_50,
    input wire logic              lcd_reset,
    input wire lcd_pkg::lcd_bus_t lcd
);

    // Consecutive cycles with en high
    int high_run;
    // Number of failed assertions
    int fail_count;

    always_ff @(posedge clock_50) begin
        if (lcd.en) begin
            high_run <= high_run + 1;
        end else begin
            high_run <= 0;
        end
    end

    en_width_a: assert property (@(posedge clock_50) disable iff (lcd_reset)
        $fell(lcd.en) |-> high_run == EN_CYCLES)
        else begin
            $error("en pulse ended before EN_CYCLES");
            fail_count++;
        end

    en_max_a: assert property (@(posedge clock_50) disable iff (lcd_reset)
        lcd.en |-> high_run < EN_CYCLES)
        else begin
            $error("en pulse longer than EN_CYCLES");
            fail_count++;
        end

    fixed_pins_a: assert property (@(posedge clock_50) !lcd.rw && lcd.on)
        else begin
            $error("rw or on pin left its fixed level");
            fail_count++;
        end

    en_in_reset_a: assert property (@(posedge clock_50) $past(lcd_reset) |-> !lcd.en)
        else begin
            $error("en high while the LCD is held in reset");
            fail_count++;
        end

endmodule

bind lcd_controller debug_display_assert #(.EN_CYCLES(EN_CYCLES)) lcd_assert_i (
    .clock_50  (clock_50),
    .lcd_reset (lcd_reset),
    .lcd       (lcd)
);

`default_nettype wire

/* tb_debug_display.sv */
//==========================================================
// Table-driven testbench for the debug display top level.
// Checks LCD transfers, hex digits and the status LEDs
//==========================================================
`timescale 1ns/1ps
`default_nettype none

module tb_debug_display;

    localparam int RESET_DELAY_CYCLES = 8;
    localparam int EN_CYCLES          = 3;
    localparam int GAP_CYCLES         = 5;
    localparam int HEARTBEAT_HALF     = 64;
    localparam int TRANSFER_CYCLES    = EN_CYCLES + GAP_CYCLES;
    localparam int NUM_TESTS          = 6;
    localparam int MARGIN_CYCLES      = 200;

    typedef struct packed {
        logic [17:0] sw;
        logic        write_lcd;
        int          transfers;
    } test_entry_t;

    logic                           clock_50 = 1'b0;
    logic                           reset;
    logic [17:0]                    sw;
    debug_display_pkg::debug_src_t  debug;
    logic [31:0]                    subject_id;
    logic [31:0]                    subject_length;
    logic [25:0]                    status;
    logic                           write_lcd;
    debug_display_pkg::seg_t [7:0]  hex;
    logic [17:0]                    ledr;
    logic [8:0]                     ledg;
    lcd_pkg::lcd_bus_t              lcd;

    test_entry_t   tests [NUM_TESTS];
    string         test_names [NUM_TESTS];
    string         current_name;
    logic [8:0]    captured [$];
    logic [1631:0] rnd_bits;
    bit            en_prev;
    logic          beat_prev;
    int            seed = 32'hcaee;
    int            cycle_count;
    int            timeout_limit;
    int            beat_cycles;
    int            toggles;
    int            lcd_pos;
    int            check_count;
    int            error_count;
    int            test_errors;

    debug_display_top #(
        .RESET_DELAY_CYCLES (RESET_DELAY_CYCLES),
        .EN_CYCLES          (EN_CYCLES),
        .GAP_CYCLES         (GAP_CYCLES),
        .HEARTBEAT_HALF     (HEARTBEAT_HALF)
    ) debug_display_top_i (
        .clock_50       (clock_50),
        .reset          (reset),
        .sw             (sw),
        .debug          (debug),
        .subject_id     (subject_id),
        .subject_length (subject_length),
        .status         (status),
        .write_lcd      (write_lcd),
        .hex            (hex),
        .ledr           (ledr),
        .ledg           (ledg),
        .lcd            (lcd)
    );

    always #10 clock_50 = ~clock_50;

    // The LCD latches data and rs where en falls
    always @(negedge clock_50) begin
        if (en_prev && !lcd.en) begin
            captured.push_back({lcd.rs, lcd.data});
        end
        en_prev <= lcd.en;
    end

    // Cycles since reset and heartbeat toggles seen at each edge
    always @(posedge clock_50) begin
        cycle_count <= cycle_count + 1;
        if (reset) begin
            beat_cycles <= 0;
            toggles     <= 0;
            beat_prev   <= 1'b0;
        end else begin
            beat_cycles <= beat_cycles + 1;
            if (ledg[8] !== beat_prev) begin
                toggles <= toggles + 1;
            end
            beat_prev <= ledg[8];
        end
    end

    //==========================================================
    // Reference model
    //==========================================================
    function automatic logic [127:0] expected_page(input logic [3:0] sel);
        int s;
        s = int'(sel);
        if (s < 3) return debug.query_data[s*128 +: 128];
        if (s < 6) return debug.subject_data[(s-3)*128 +: 128];
        if (s == 6) return {40'd0, debug.misc_debug};
        if (s < 10) return debug.query_debug[(s-7)*128 +: 128];
        if (s < 13) return debug.subject_debug[(s-10)*128 +: 128];
        return '0;
    endfunction

    function automatic logic [7:0] hex_char(input logic [3:0] n);
        if (n <= 4'd9) return 8'h30 + {4'h0, n};
        return 8'h41 + {4'h0, n} - 8'd10;
    endfunction

    // Positions 0-3 are init, 4-37 the refresh loop
    function automatic logic [8:0] expected_transfer(input int pos, input logic [127:0] pg);
        int p;
        int k;
        case (pos)
            0: return {1'b0, lcd_pkg::CMD_FUNCTION_SET};
            1: return {1'b0, lcd_pkg::CMD_DISPLAY_ON};
            2: return {1'b0, lcd_pkg::CMD_CLEAR};
            3: return {1'b0, lcd_pkg::CMD_ENTRY_MODE};
            default: p = pos - 4;
        endcase
        if (p == 16) return {1'b0, lcd_pkg::CMD_LINE2};
        if (p == 33) return {1'b0, lcd_pkg::CMD_LINE1};
        k = (p < 16) ? p : p - 1;
        return {1'b1, hex_char(pg[4*(31-k) +: 4])};
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        assert (actual === expected) else begin
            $display("CHECK FAILED %s %s: expected %0h, actual %0h",
                     current_name, what, expected, actual);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic run_test(input int t);
        test_entry_t e;
        logic [127:0] pg;
        logic [31:0]  rnd;
        logic [31:0]  word;
        logic [8:0]   got;
        int           toggles_now;
        e            = tests[t];
        current_name = test_names[t];
        test_errors  = 0;
        rnd          = $random(seed);
        @(posedge clock_50);
        sw             <= e.sw;
        status         <= rnd[25:0];
        subject_id     <= $random(seed);
        subject_length <= $random(seed);
        if (e.write_lcd) begin
            write_lcd <= 1'b1;
            @(posedge clock_50);
            write_lcd <= 1'b0;
            lcd_pos = 0;
        end
        pg = expected_page(e.sw[17:14]);
        for (int i = 0; i < e.transfers; i++) begin
            while (captured.size() == 0) @(posedge clock_50);
            got = captured.pop_front();
            check_value("lcd transfer", 32'(expected_transfer(lcd_pos, pg)), 32'(got));
            lcd_pos = (lcd_pos == 37) ? 4 : lcd_pos + 1;
        end
        @(negedge clock_50);
        word = e.sw[10] ? subject_id : subject_length;
        for (int k = 0; k < 8; k++) begin
            check_value("hex digit", 32'(debug_display_pkg::SEG_FONT[word[4*k +: 4]]),
                        32'(hex[k]));
        end
        check_value("ledr", 32'(status[25:8]), 32'(ledr));
        check_value("ledg", 32'(status[7:0]), 32'(ledg[7:0]));
        // Include a toggle made by the latest edge
        toggles_now = toggles + ((ledg[8] !== beat_prev) ? 1 : 0);
        check_value("heartbeat toggles", beat_cycles / HEARTBEAT_HALF, toggles_now);
        $display("%-22s %s, %0d errors", current_name,
                 (test_errors == 0) ? "pass" : "FAIL", test_errors);
    endtask

    //==========================================================
    // Test table and main sequence
    //==========================================================
    initial begin
        tests[0] = '{sw: {4'd0, 3'd0, 1'b0, 10'd0}, write_lcd: 1'b0, transfers: 4};
        tests[1] = '{sw: {4'd0, 3'd0, 1'b0, 10'd0}, write_lcd: 1'b0, transfers: 34};
        tests[2] = '{sw: {4'd4, 3'd0, 1'b0, 10'd0}, write_lcd: 1'b0, transfers: 34};
        tests[3] = '{sw: {4'd6, 3'd0, 1'b1, 10'd0}, write_lcd: 1'b0, transfers: 34};
        tests[4] = '{sw: {4'd13, 3'd0, 1'b1, 10'd0}, write_lcd: 1'b0, transfers: 34};
        tests[5] = '{sw: {4'd2, 3'd0, 1'b0, 10'd0}, write_lcd: 1'b1, transfers: 6};
        test_names[0] = "init_after_reset";
        test_names[1] = "page0_query_data";
        test_names[2] = "page4_subject_data";
        test_names[3] = "page6_misc_debug";
        test_names[4] = "page13_blank";
        test_names[5] = "write_lcd_restart";

        timeout_limit = RESET_DELAY_CYCLES + MARGIN_CYCLES;
        for (int t = 0; t < NUM_TESTS; t++) begin
            timeout_limit += tests[t].transfers * TRANSFER_CYCLES;
            if (tests[t].write_lcd) timeout_limit += RESET_DELAY_CYCLES;
        end

        for (int i = 0; i < 51; i++) begin
            rnd_bits[i*32 +: 32] = $random(seed);
        end
        debug          = debug_display_pkg::debug_src_t'(rnd_bits[1623:0]);
        reset          = 1'b1;
        sw             = '0;
        subject_id     = '0;
        subject_length = '0;
        status         = '0;
        write_lcd      = 1'b0;

        repeat (2) @(posedge clock_50);
        reset <= 1'b0;

        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end

        // Failures of the bound LCD bus assertions
        error_count += debug_display_top_i.lcd_controller_i.lcd_assert_i.fail_count;

        $display("Summary: %0d tests, %0d checks, %0d errors",
                 NUM_TESTS, check_count, error_count);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog on the whole run
    initial begin
        @(posedge clock_50);
        while (cycle_count < timeout_limit) @(posedge clock_50);
        $display("Timeout: LCD transfers did not arrive within %0d cycles", timeout_limit);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
debug_display_pkg.sv
lcd_pkg.sv
reset_delay.sv
page_select.sv
hex_ascii_encoder.sv
seven_seg_bank.sv
status_leds.sv
lcd_controller.sv
debug_display_top.sv
debug_display_assert.sv
tb_debug_display.sv

/* run_sim.sh */
#!/bin/sh
# Builds the debug display testbench with Verilator and runs it.
# Exit status is 0 on a passing run.

cd "$(dirname "$0")" || exit 1

TOP=tb_debug_display
LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module "$TOP" -o "$TOP"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "Test failed" "$LOG"; then
    exit 1
fi
exit 0
